// File: include/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath and address width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_REG_COUNT 32

`define RV_RESET_PC 32'h8000_0000  // first fetch address

`endif

// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // instruction class, codes follow the decoder key
    typedef enum logic [2:0] {
        class_i   = 3'b000,  // op-imm
        class_n   = 3'b001,  // system, ecall / ebreak
        class_u   = 3'b010,  // lui auipc
        class_r   = 3'b011,  // op reg-reg
        class_s   = 3'b100,  // store
        class_ill = 3'b111   // anything else
    } inst_class_e;

    // alu function
    typedef enum logic [2:0] {
        alu_add      = 3'd0,
        alu_sub      = 3'd1,
        alu_sltu     = 3'd2,
        alu_sra      = 3'd3,
        alu_and      = 3'd4,
        alu_pass_imm = 3'd5  // lui
    } alu_op_e;

    // store width, funct3 of the store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } store_size_e;

    // system op
    typedef enum logic [1:0] {
        sys_none   = 2'd0,
        sys_ecall  = 2'd1,
        sys_ebreak = 2'd2
    } sys_op_e;

endpackage

`default_nettype wire

// File: source/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

// decoded instruction fields, decoder -> execute
interface decode_if;

    rv_pkg::inst_class_e                inst_class;
    rv_pkg::alu_op_e                    alu_op;
    rv_pkg::store_size_e                store_size;
    rv_pkg::sys_op_e                    sys_op;
    logic [$clog2(`RV_REG_COUNT)-1:0]   rd;
    logic [$clog2(`RV_REG_COUNT)-1:0]   rs1;
    logic [$clog2(`RV_REG_COUNT)-1:0]   rs2;
    logic [`RV_XLEN-1:0]                imm;
    logic                               use_pc;     // auipc, operand a is pc
    logic                               writes_rd;

    modport producer (output inst_class, alu_op, store_size, sys_op,
                      output rd, rs1, rs2, imm, use_pc, writes_rd);

    modport consumer (input inst_class, alu_op, store_size, sys_op,
                      input rd, rs1, rs2, imm, use_pc, writes_rd);

endinterface

`default_nettype wire

// File: source/rf_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

// register file ports, two reads and one write
interface rf_if;

    logic [$clog2(`RV_REG_COUNT)-1:0]   raddr1;
    logic [$clog2(`RV_REG_COUNT)-1:0]   raddr2;
    logic [`RV_XLEN-1:0]                rdata1;
    logic [`RV_XLEN-1:0]                rdata2;
    logic                               we;
    logic [$clog2(`RV_REG_COUNT)-1:0]   waddr;
    logic [`RV_XLEN-1:0]                wdata;

    modport reader_addr (output raddr1, raddr2);  // decoder side

    modport storage (input raddr1, raddr2, we, waddr, wdata, output rdata1, rdata2);

    modport writer (input rdata1, rdata2, output we, waddr, wdata);  // execute side

endinterface

`default_nettype wire

// File: source/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module inst_decode (
    input  logic [`RV_XLEN-1:0] inst,
    decode_if.producer          dec,
    rf_if.reader_addr           rf
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rv_pkg::inst_class_e    cls;
    rv_pkg::alu_op_e        op;
    rv_pkg::store_size_e    size;
    rv_pkg::sys_op_e        sys;
    logic                   pc_rel;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // opcode class first, then sub-op; bad variants fall back to class_ill
    always_comb begin
        cls    = rv_pkg::class_ill;
        op     = rv_pkg::alu_add;
        size   = rv_pkg::size_word;
        sys    = rv_pkg::sys_none;
        pc_rel = 1'b0;
        case (opcode)
            7'b0010011: begin  // op-imm
                cls = rv_pkg::class_i;
                case (funct3)
                    3'b000: op = rv_pkg::alu_add;   // addi
                    3'b011: op = rv_pkg::alu_sltu;  // sltiu
                    3'b111: op = rv_pkg::alu_and;   // andi
                    3'b101: begin
                        op = rv_pkg::alu_sra;       // srai only, srli dropped
                        if (funct7 != 7'b0100000)
                            cls = rv_pkg::class_ill;
                    end
                    default: cls = rv_pkg::class_ill;
                endcase
            end
            7'b1110011: begin  // system, exact match on 31..7
                cls = rv_pkg::class_n;
                if (inst[31:7] == 25'b0)
                    sys = rv_pkg::sys_ecall;
                else if (inst[31:7] == 25'b0000000000010000000000000)
                    sys = rv_pkg::sys_ebreak;
                else
                    cls = rv_pkg::class_ill;  // csr ops etc
            end
            7'b0110111: begin  // lui
                cls = rv_pkg::class_u;
                op  = rv_pkg::alu_pass_imm;
            end
            7'b0010111: begin  // auipc
                cls    = rv_pkg::class_u;
                op     = rv_pkg::alu_add;
                pc_rel = 1'b1;
            end
            7'b0110011: begin  // op
                cls = rv_pkg::class_r;
                if (funct3 == 3'b000 && funct7 == 7'b0000000)
                    op = rv_pkg::alu_add;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000)
                    op = rv_pkg::alu_sub;
                else
                    cls = rv_pkg::class_ill;
            end
            7'b0100011: begin  // store
                cls = rv_pkg::class_s;
                case (funct3)
                    3'b000:  size = rv_pkg::size_byte;
                    3'b001:  size = rv_pkg::size_half;
                    3'b010:  size = rv_pkg::size_word;
                    default: cls = rv_pkg::class_ill;
                endcase
            end
            default: cls = rv_pkg::class_ill;
        endcase
    end

    // immediate by class
    always_comb begin
        case (cls)
            rv_pkg::class_i: dec.imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::class_s: dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_pkg::class_u: dec.imm = {inst[31:12], 12'b0};
            default:         dec.imm = '0;
        endcase
    end

    assign dec.inst_class = cls;
    assign dec.alu_op     = op;
    assign dec.store_size = size;
    assign dec.sys_op     = sys;
    assign dec.use_pc     = pc_rel;
    assign dec.rd         = inst[11:7];
    assign dec.rs1        = (opcode == 7'b0110111) ? '0 : inst[19:15];  // lui reads x0
    assign dec.rs2        = inst[24:20];
    assign dec.writes_rd  = (cls == rv_pkg::class_i) || (cls == rv_pkg::class_u) ||
                            (cls == rv_pkg::class_r);

    // register reads straight from the decoded indices
    assign rf.raddr1 = dec.rs1;
    assign rf.raddr2 = dec.rs2;

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module reg_file (
    input  logic    clk,
    input  logic    rst,
    rf_if.storage   rf
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // one write port, x0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;  // known start state
            end
        end else if (rf.we && rf.waddr != '0) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // async reads, x0 forced to zero
    always_comb begin
        if (rf.raddr1 == '0)
            rf.rdata1 = '0;
        else
            rf.rdata1 = regs[rf.raddr1];
    end

    always_comb begin
        if (rf.raddr2 == '0)
            rf.rdata2 = '0;
        else
            rf.rdata2 = regs[rf.raddr2];
    end

endmodule

`default_nettype wire

// File: source/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module exec_stage (
    input  logic                clk,
    input  logic                rst,
    decode_if.consumer          dec,
    rf_if.writer                rf,
    output logic [`RV_XLEN-1:0] pc,
    output logic                store_en,
    output logic [`RV_XLEN-1:0] store_addr,
    output logic [`RV_XLEN-1:0] store_data,
    output logic [3:0]          store_strb,
    output logic                halt,
    output logic                ecall,
    output logic                illegal
);

    logic                   active;     // not halted, not in reset
    logic                   is_store;
    logic                   is_ebreak;
    logic [`RV_XLEN-1:0]    op_a;
    logic [`RV_XLEN-1:0]    op_b;
    logic [`RV_XLEN-1:0]    alu_out;
    logic [`RV_XLEN-1:0]    eff_addr;
    logic [3:0]             lanes;

    assign active    = ~halt & ~rst;
    assign is_store  = (dec.inst_class == rv_pkg::class_s);
    assign is_ebreak = (dec.inst_class == rv_pkg::class_n) &&
                       (dec.sys_op == rv_pkg::sys_ebreak);

    // pc and halt state
    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= `RV_RESET_PC;
            halt <= 1'b0;
        end else if (!halt) begin
            pc <= pc + `RV_XLEN'd4;
            if (is_ebreak)
                halt <= 1'b1;  // sticky until reset
        end
    end

    // operand select
    assign op_a = dec.use_pc ? pc : rf.rdata1;
    assign op_b = (dec.inst_class == rv_pkg::class_r) ? rf.rdata2 : dec.imm;

    always_comb begin
        case (dec.alu_op)
            rv_pkg::alu_add:      alu_out = op_a + op_b;
            rv_pkg::alu_sub:      alu_out = op_a - op_b;
            rv_pkg::alu_sltu:     alu_out = {{(`RV_XLEN-1){1'b0}}, rf.rdata1 < dec.imm};
            rv_pkg::alu_sra:      alu_out = $signed(rf.rdata1) >>> dec.imm[4:0];
            rv_pkg::alu_and:      alu_out = rf.rdata1 & dec.imm;
            rv_pkg::alu_pass_imm: alu_out = dec.imm;  // lui
            default:              alu_out = '0;
        endcase
    end

    // writeback
    assign rf.we    = dec.writes_rd & ~halt;
    assign rf.waddr = dec.rd;
    assign rf.wdata = alu_out;

    // store path, address is rs1 + s-imm
    assign eff_addr = rf.rdata1 + dec.imm;

    always_comb begin
        case (dec.store_size)
            rv_pkg::size_byte: begin
                store_data = {4{rf.rdata2[7:0]}};   // byte on every lane
                lanes      = 4'b0001 << eff_addr[1:0];
            end
            rv_pkg::size_half: begin
                store_data = {2{rf.rdata2[15:0]}};
                lanes      = eff_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_data = rf.rdata2;
                lanes      = 4'b1111;  // word, misalignment ignored
            end
        endcase
    end

    assign store_en   = is_store & active;
    assign store_addr = {eff_addr[`RV_XLEN-1:2], 2'b00};
    assign store_strb = store_en ? lanes : 4'b0000;

    // one-cycle flags
    assign ecall   = active && (dec.inst_class == rv_pkg::class_n) &&
                     (dec.sys_op == rv_pkg::sys_ecall);
    assign illegal = active && (dec.inst_class == rv_pkg::class_ill);

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core (
    input  logic                clk,
    input  logic                rst,
    input  logic [`RV_XLEN-1:0] inst,
    output logic [`RV_XLEN-1:0] pc,
    output logic                store_en,
    output logic [`RV_XLEN-1:0] store_addr,
    output logic [`RV_XLEN-1:0] store_data,
    output logic [3:0]          store_strb,
    output logic                halt,
    output logic                ecall,
    output logic                illegal
);

    decode_if dec_bus ();
    rf_if     rf_bus ();

    // decode, comb from inst
    inst_decode inst_decode_inst (
        .inst (inst),
        .dec  (dec_bus.producer),
        .rf   (rf_bus.reader_addr)
    );

    // x1..x31
    reg_file reg_file_inst (
        .clk (clk),
        .rst (rst),
        .rf  (rf_bus.storage)
    );

    // alu, pc, store and flags
    exec_stage exec_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec_bus.consumer),
        .rf         (rf_bus.writer),
        .pc         (pc),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_strb (store_strb),
        .halt       (halt),
        .ecall      (ecall),
        .illegal    (illegal)
    );

endmodule

`default_nettype wire

// File: tests/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core_tb;

    localparam int NUM_RANDOM     = 2000;
    localparam int NUM_AFTER_HALT = 10;
    localparam int CYCLE_LIMIT    = NUM_RANDOM + 1 + NUM_AFTER_HALT + 89;  // 2100

    logic                   clk;
    logic                   rst;
    logic [`RV_XLEN-1:0]    inst;
    logic [`RV_XLEN-1:0]    pc;
    logic                   store_en;
    logic [`RV_XLEN-1:0]    store_addr;
    logic [`RV_XLEN-1:0]    store_data;
    logic [3:0]             store_strb;
    logic                   halt;
    logic                   ecall;
    logic                   illegal;

    // reference model state
    logic [`RV_XLEN-1:0]    model_regs [32];
    logic [`RV_XLEN-1:0]    model_pc;
    logic                   model_halt;

    // expected response to the word on inst
    logic                   exp_we;
    logic [4:0]             exp_rd;
    logic [`RV_XLEN-1:0]    exp_val;
    logic                   exp_store_en;
    logic [`RV_XLEN-1:0]    exp_addr;
    logic [`RV_XLEN-1:0]    exp_data;
    logic [3:0]             exp_strb;
    logic                   exp_ecall;
    logic                   exp_ill;
    logic                   exp_ebreak;

    int                     errors;
    int                     cycles;
    int unsigned            seed_ret;

    rv_core rv_core_inst (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .pc         (pc),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_strb (store_strb),
        .halt       (halt),
        .ecall      (ecall),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
        errors++;
    endtask

    // weighted random word from the supported set plus some junk
    function automatic logic [31:0] gen_inst();
        logic [4:0]     rd;
        logic [4:0]     rs1;
        logic [4:0]     rs2;
        logic [11:0]    imm;
        int             kind;
        rd   = $urandom;
        rs1  = $urandom;
        rs2  = $urandom;
        imm  = $urandom;
        kind = $urandom % 20;
        case (kind)
            0, 1, 2, 19: return {imm, rs1, 3'b000, rd, 7'h13};  // addi
            3:  return {imm, rs1, 3'b011, rd, 7'h13};           // sltiu
            4:  return {7'b0100000, imm[4:0], rs1, 3'b101, rd, 7'h13};  // srai
            5:  return {imm, rs1, 3'b111, rd, 7'h13};           // andi
            6:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'h33};
            7:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'h33};
            8:  return {imm, rs1, rs2[2:0], rd, 7'h37};         // lui, top 20 random
            9:  return {imm, rs1, rs2[2:0], rd, 7'h17};         // auipc
            10, 11: return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'h23};
            12, 13: return {imm[11:5], rs2, rs1, 3'b001, imm[4:0], 7'h23};
            14, 15: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
            16: return 32'h0000_0073;                           // ecall
            17: return $urandom;                                // anything
            default: begin
                case ($urandom % 4)
                    0: return {imm, rs1, 3'b001, rd, 7'h13};    // slli
                    1: return {7'b0000001, rs2, rs1, 3'b000, rd, 7'h33};  // mul
                    2: return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23};  // sd
                    default: return {7'b0000000, imm[4:0], rs1, 3'b101, rd, 7'h13};
                endcase
            end
        endcase
    endfunction

    // isa rules for one word against current model state
    task automatic model_eval(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] ea;
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        ea    = a + imm_s;
        exp_we       = 1'b0;
        exp_rd       = w[11:7];
        exp_val      = '0;
        exp_store_en = 1'b0;
        exp_addr     = {ea[31:2], 2'b00};
        exp_data     = '0;
        exp_strb     = 4'b0000;
        exp_ecall    = 1'b0;
        exp_ill      = 1'b0;
        exp_ebreak   = 1'b0;
        case (w[6:0])
            7'h13: begin
                exp_we = 1'b1;
                if (w[14:12] == 3'b000)
                    exp_val = a + imm_i;
                else if (w[14:12] == 3'b011)
                    exp_val = (a < imm_i) ? 32'd1 : 32'd0;  // unsigned compare
                else if (w[14:12] == 3'b111)
                    exp_val = a & imm_i;
                else if (w[14:12] == 3'b101 && w[31:25] == 7'b0100000)
                    exp_val = $signed(a) >>> w[24:20];
                else
                    exp_ill = 1'b1;
            end
            7'h33: begin
                exp_we = 1'b1;
                if (w[14:12] == 3'b000 && w[31:25] == 7'b0000000)
                    exp_val = a + b;
                else if (w[14:12] == 3'b000 && w[31:25] == 7'b0100000)
                    exp_val = a - b;
                else
                    exp_ill = 1'b1;
            end
            7'h37: begin
                exp_we  = 1'b1;
                exp_val = {w[31:12], 12'b0};
            end
            7'h17: begin
                exp_we  = 1'b1;
                exp_val = model_pc + {w[31:12], 12'b0};
            end
            7'h23: begin
                exp_store_en = 1'b1;
                case (w[14:12])
                    3'b000: begin
                        exp_data = {4{b[7:0]}};
                        exp_strb = 4'b0001 << ea[1:0];
                    end
                    3'b001: begin
                        exp_data = {2{b[15:0]}};
                        exp_strb = ea[1] ? 4'b1100 : 4'b0011;
                    end
                    3'b010: begin
                        exp_data = b;
                        exp_strb = 4'b1111;
                    end
                    default: exp_ill = 1'b1;
                endcase
            end
            7'h73: begin
                if (w[31:7] == 25'd0)
                    exp_ecall = 1'b1;
                else if (w[31:7] == 25'h0002000)
                    exp_ebreak = 1'b1;
                else
                    exp_ill = 1'b1;
            end
            default: exp_ill = 1'b1;
        endcase
        if (exp_ill) begin
            exp_we       = 1'b0;  // dropped, no side effects
            exp_store_en = 1'b0;
        end
        if (model_halt) begin
            exp_we       = 1'b0;
            exp_store_en = 1'b0;
            exp_ecall    = 1'b0;
            exp_ill      = 1'b0;
            exp_ebreak   = 1'b0;
        end
    endtask

    task automatic model_commit();
        if (!model_halt) begin
            if (exp_we && exp_rd != 5'd0)
                model_regs[exp_rd] = exp_val;
            if (exp_ebreak)
                model_halt = 1'b1;
            model_pc = model_pc + 32'd4;
        end
    endtask

    task automatic check_outputs();
        if (pc !== model_pc)
            report_mismatch("pc", model_pc, pc);
        if (halt !== model_halt)
            report_mismatch("halt", model_halt, halt);
        if (store_en !== exp_store_en)
            report_mismatch("store_en", exp_store_en, store_en);
        if (exp_store_en) begin
            if (store_addr !== exp_addr)
                report_mismatch("store_addr", exp_addr, store_addr);
            if (store_data !== exp_data)
                report_mismatch("store_data", exp_data, store_data);
            if (store_strb !== exp_strb)
                report_mismatch("store_strb", exp_strb, store_strb);
        end
        if (ecall !== exp_ecall)
            report_mismatch("ecall", exp_ecall, ecall);
        if (illegal !== exp_ill)
            report_mismatch("illegal", exp_ill, illegal);
    endtask

    // reset holds pc and keeps every strobe low whatever the word
    task automatic check_reset_state();
        if (pc !== `RV_RESET_PC)
            report_mismatch("pc", `RV_RESET_PC, pc);
        if (halt !== 1'b0)
            report_mismatch("halt", 32'd0, halt);
        if (store_en !== 1'b0)
            report_mismatch("store_en", 32'd0, store_en);
        if (ecall !== 1'b0)
            report_mismatch("ecall", 32'd0, ecall);
        if (illegal !== 1'b0)
            report_mismatch("illegal", 32'd0, illegal);
    endtask

    // entered 1 ns after a rising edge, leaves 1 ns after the next one
    task automatic run_inst(input logic [31:0] w);
        inst = w;
        model_eval(w);
        #17;  // sample 2 ns before the edge
        check_outputs();
        model_commit();
        @(posedge clk);
        #1;
    endtask

    initial begin
        errors   = 0;
        seed_ret = $urandom(32'h8afe8846);
        rst      = 1'b1;
        inst     = 32'h0000_2023;  // sw x0, 0(x0) first
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc   = `RV_RESET_PC;
        model_halt = 1'b0;
        // store, ecall and junk words in turn while rst is high
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            check_reset_state();
            case (i % 3)
                0:       inst = 32'h0000_0073;  // ecall
                1:       inst = 32'hffff_ffff;  // illegal
                default: inst = 32'h0000_2023;  // sw x0, 0(x0)
            endcase
        end
        rst = 1'b0;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            run_inst(gen_inst());
        end
        run_inst(32'h0010_0073);  // ebreak
        for (int n = 0; n < NUM_AFTER_HALT; n++) begin
            run_inst(gen_inst());
        end
        $display("Instructions run %0d, errors %0d", NUM_RANDOM + 1 + NUM_AFTER_HALT, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // watchdog, counts cycles after reset
    initial begin
        cycles = 0;
        wait (rst === 1'b0);
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles after reset", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
source/rv_pkg.sv
source/decode_if.sv
source/rf_if.sv
source/inst_decode.sv
source/reg_file.sv
source/exec_stage.sv
source/rv_core.sv
tests/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - files:
      - source/rv_pkg.sv
      - source/decode_if.sv
      - source/rf_if.sv
      - source/inst_decode.sv
      - source/reg_file.sv
      - source/exec_stage.sv
      - source/rv_core.sv
  - target: test
    files:
      - tests/rv_core_tb.sv
